// ==== logic/apb_gpio.sv ====
`timescale 1ns/1ps

module apb_gpio
    import soc_map_pkg::*;
(
    input logic i_clk,
    input logic i_reset,
    input logic i_sel,
    input logic i_penable,
    input logic i_pwrite,
    input logic [4:0] i_paddr,
    input logic [31:0] i_pwdata,
    output logic [31:0] o_prdata,
    input logic [SOC_GPIO_WIDTH-1:0] i_gpio,                // Pins, asynchronous to i_clk
    output logic [SOC_GPIO_WIDTH-1:0] o_gpio,
    output logic [SOC_GPIO_WIDTH-1:0] o_gpio_dir,           // 1 = output pin
    output logic [SOC_GPIO_WIDTH-1:0] o_irq_lines           // Per-pin level to the controller
);

logic [SOC_GPIO_WIDTH-1:0] out_q;
logic [SOC_GPIO_WIDTH-1:0] dir_q;
logic [SOC_GPIO_WIDTH-1:0] ie_q;
logic [SOC_GPIO_WIDTH-1:0] pend_q;
logic [SOC_GPIO_WIDTH-1:0] sync1_q;
logic [SOC_GPIO_WIDTH-1:0] sync2_q;
logic [SOC_GPIO_WIDTH-1:0] prev_q;                          // sync2_q one cycle later
logic [SOC_GPIO_WIDTH-1:0] rise;
logic wr_en;

assign wr_en = i_sel & i_penable & i_pwrite;

// Rising edges on input pins only
assign rise = sync2_q & ~prev_q & ~dir_q;

always_ff @(posedge i_clk)
begin
    if (i_reset)
    begin
        out_q <= '0;
        dir_q <= '0;                                        // All pins start as inputs
        ie_q <= '0;
        pend_q <= '0;
        sync1_q <= '0;
        sync2_q <= '0;
        prev_q <= '0;
    end
    else
    begin
        sync1_q <= i_gpio;
        sync2_q <= sync1_q;
        prev_q <= sync2_q;

        // A new edge wins over a clear in the same cycle
        if (wr_en && i_paddr == GPIO_REG_PEND)
        begin
            pend_q <= (pend_q & ~i_pwdata[SOC_GPIO_WIDTH-1:0]) | rise;
        end
        else
        begin
            pend_q <= pend_q | rise;
        end

        if (wr_en && i_paddr == GPIO_REG_OUTPUT)
        begin
            out_q <= i_pwdata[SOC_GPIO_WIDTH-1:0];
        end
        if (wr_en && i_paddr == GPIO_REG_DIR)
        begin
            dir_q <= i_pwdata[SOC_GPIO_WIDTH-1:0];
        end
        if (wr_en && i_paddr == GPIO_REG_IE)
        begin
            ie_q <= i_pwdata[SOC_GPIO_WIDTH-1:0];
        end
    end
end

// Read path straight from the registers
always_comb
begin
    case (i_paddr)
        GPIO_REG_INPUT: o_prdata = 32'(sync2_q);
        GPIO_REG_OUTPUT: o_prdata = 32'(out_q);
        GPIO_REG_DIR: o_prdata = 32'(dir_q);
        GPIO_REG_IE: o_prdata = 32'(ie_q);
        GPIO_REG_PEND: o_prdata = 32'(pend_q);
        default: o_prdata = '0;
    endcase
end

assign o_gpio = out_q;
assign o_gpio_dir = dir_q;
assign o_irq_lines = pend_q & ie_q;

endmodule: apb_gpio

// ==== logic/apb_irq_ctrl.sv ====
`timescale 1ns/1ps

module apb_irq_ctrl
    import soc_map_pkg::*;
(
    input logic i_clk,
    input logic i_reset,
    input logic i_sel,
    input logic i_penable,
    input logic i_pwrite,
    input logic [3:0] i_paddr,
    input logic [31:0] i_pwdata,
    output logic [31:0] o_prdata,
    input logic [SOC_GPIO_WIDTH-1:0] i_gpio_irq,            // Levels from the GPIO block
    output logic o_irq
);

logic [SOC_IRQ_TOTAL-1:0] src;
logic [SOC_IRQ_TOTAL-1:0] pend_q;
logic [SOC_IRQ_TOTAL-1:0] pend_d;
logic [SOC_IRQ_TOTAL-1:0] en_q;
logic [SOC_IRQ_TOTAL-1:0] active;
logic [$clog2(SOC_IRQ_TOTAL)-1:0] claim_id;
logic pend_wr;
logic en_wr;
logic claim_rd;

assign pend_wr = i_sel & i_penable & i_pwrite & (i_paddr == IRQ_REG_PEND);
assign en_wr = i_sel & i_penable & i_pwrite & (i_paddr == IRQ_REG_ENABLE);
assign claim_rd = i_sel & i_penable & ~i_pwrite & (i_paddr == IRQ_REG_CLAIM);

// Source map, ids 0 and 13 to 14 have no hardware source
always_comb
begin
    src = '0;
    src[SOC_IRQ_GPIO_BASE +: SOC_GPIO_WIDTH] = i_gpio_irq;
end

assign active = pend_q & en_q;

// Lowest active id wins
always_comb
begin
    claim_id = '0;
    for (int i = SOC_IRQ_TOTAL - 1; i > 0; i--)
    begin
        if (active[i])
        begin
            claim_id = ($clog2(SOC_IRQ_TOTAL))'(i);
        end
    end
end

// Clears win for one cycle, a source still high pends again after that.
// Clear the GPIO pending bit before claiming, or the id comes straight back
always_comb
begin
    pend_d = pend_q | src;
    if (pend_wr)
    begin
        pend_d[SOC_IRQ_GPIO_BASE +: SOC_GPIO_WIDTH] =
            pend_d[SOC_IRQ_GPIO_BASE +: SOC_GPIO_WIDTH] &
            ~i_pwdata[SOC_IRQ_GPIO_BASE +: SOC_GPIO_WIDTH];
        pend_d[SOC_IRQ_SOFT] = pend_d[SOC_IRQ_SOFT] | i_pwdata[SOC_IRQ_SOFT];
    end
    if (claim_rd)
    begin
        pend_d[claim_id] = 1'b0;                            // Id 0 is never pending
    end
end

always_ff @(posedge i_clk)
begin
    if (i_reset)
    begin
        pend_q <= '0;
        en_q <= '0;
    end
    else
    begin
        pend_q <= pend_d;
        if (en_wr)
        begin
            en_q <= i_pwdata[SOC_IRQ_TOTAL-1:0];
        end
    end
end

always_comb
begin
    case (i_paddr)
        IRQ_REG_PEND: o_prdata = 32'(pend_q);
        IRQ_REG_ENABLE: o_prdata = 32'(en_q);
        IRQ_REG_CLAIM: o_prdata = 32'(claim_id);
        default: o_prdata = '0;
    endcase
end

assign o_irq = |active;

endmodule: apb_irq_ctrl

// ==== logic/apb_pnp.sv ====
`timescale 1ns/1ps

module apb_pnp
    import soc_map_pkg::*;
    import soc_pnp_pkg::*;
(
    input logic i_clk,
    input logic i_reset,
    input logic i_sel,
    input logic i_penable,
    input logic i_pwrite,
    input logic [5:0] i_paddr,
    input logic [31:0] i_pwdata,
    output logic [31:0] o_prdata
);

logic [31:0] scratch_q;
logic [15:0] dev_code [PNP_TABLE_SIZE];
logic [5:0] tbl_offs;                                       // Byte offset inside the table
logic in_table;
logic wr_en;

// Device codes in slot order
assign dev_code[SOC_SLOT_GPIO] = PNP_DEV_GPIO;
assign dev_code[SOC_SLOT_IRQ] = PNP_DEV_IRQ;
assign dev_code[SOC_SLOT_PNP] = PNP_DEV_PNP;

assign tbl_offs = i_paddr - PNP_REG_TABLE;
assign in_table = (i_paddr >= PNP_REG_TABLE) && (tbl_offs[1:0] == 2'b00)
               && (tbl_offs[5:2] < 4'(PNP_TABLE_SIZE));

assign wr_en = i_sel & i_penable & i_pwrite & (i_paddr == PNP_REG_SCRATCH);

always_ff @(posedge i_clk)
begin
    if (i_reset)
    begin
        scratch_q <= '0;
    end
    else if (wr_en)
    begin
        scratch_q <= i_pwdata;                              // Only writable word
    end
end

always_comb
begin
    o_prdata = '0;
    if (in_table)
    begin
        o_prdata = {PNP_VENDOR_ID, dev_code[tbl_offs[3:2]]};
    end
    else if (i_paddr == PNP_REG_SCRATCH)
    begin
        o_prdata = scratch_q;
    end
    else if (i_paddr == 6'h00)
    begin
        o_prdata = SOC_HW_ID;                               // Hardware id at offset 0
    end
end

endmodule: apb_pnp

// ==== logic/apb_resp_mux.sv ====
`timescale 1ns/1ps

module apb_resp_mux
    import soc_map_pkg::*;
(
    input logic [SOC_SLOT_TOTAL-1:0] i_sel,                 // One-hot from the decoder
    input logic i_unmapped,
    input logic i_penable,
    input logic [31:0] i_prdata_gpio,
    input logic [31:0] i_prdata_irq,
    input logic [31:0] i_prdata_pnp,
    output logic [31:0] o_prdata,
    output logic o_pready,
    output logic o_pslverr
);

// Zero when idle or unmapped
always_comb
begin
    o_prdata = '0;
    if (i_sel[SOC_SLOT_GPIO])
    begin
        o_prdata = i_prdata_gpio;
    end
    else if (i_sel[SOC_SLOT_IRQ])
    begin
        o_prdata = i_prdata_irq;
    end
    else if (i_sel[SOC_SLOT_PNP])
    begin
        o_prdata = i_prdata_pnp;
    end
end

assign o_pready = i_penable;                                // No wait states anywhere
assign o_pslverr = i_penable & i_unmapped;

endmodule: apb_resp_mux

// ==== logic/apb_slot_decoder.sv ====
`timescale 1ns/1ps

module apb_slot_decoder
(
    input logic i_psel,                                     // APB select from the master
    input logic [15:12] i_paddr,                            // Slot number field
    output logic [2:0] o_sel,                               // One-hot slave select
    output logic o_unmapped                                 // Access to an empty slot
);

logic [2:0] slot_hit;
logic slot_valid;

// Decode the slot number regardless of psel
always_comb
begin
    slot_hit = 3'b000;
    case (i_paddr)
        4'd0: slot_hit = 3'b001;                            // GPIO
        4'd1: slot_hit = 3'b010;                            // Interrupt controller
        4'd2: slot_hit = 3'b100;                            // Plug-and-play table
        default: slot_hit = 3'b000;
    endcase
end

assign slot_valid = |slot_hit;

// Nothing leaves the decoder while the bus is idle
always_comb
begin
    o_sel = 3'b000;
    o_unmapped = 1'b0;
    if (i_psel)
    begin
        o_sel = slot_hit;
        o_unmapped = ~slot_valid;                           // Slots 3 to 15
    end
end

endmodule: apb_slot_decoder

// ==== logic/periph_subsys.sv ====
`timescale 1ns/1ps

module periph_subsys
    import soc_map_pkg::*;
(
    input logic i_clk,
    input logic i_reset,
    // APB slave port
    input logic i_psel,
    input logic i_penable,
    input logic i_pwrite,
    input logic [15:0] i_paddr,
    input logic [31:0] i_pwdata,
    output logic o_pready,
    output logic [31:0] o_prdata,
    output logic o_pslverr,
    // GPIO pins
    input logic [SOC_GPIO_WIDTH-1:0] i_gpio,
    output logic [SOC_GPIO_WIDTH-1:0] o_gpio,
    output logic [SOC_GPIO_WIDTH-1:0] o_gpio_dir,
    output logic o_irq                                      // External interrupt to the hart
);

logic [SOC_SLOT_TOTAL-1:0] wb_sel;
logic w_unmapped;
logic [31:0] wb_prdata_gpio;
logic [31:0] wb_prdata_irq;
logic [31:0] wb_prdata_pnp;
logic [SOC_GPIO_WIDTH-1:0] wb_irq_gpio;

apb_slot_decoder decoder0 (
    .i_psel(i_psel),
    .i_paddr(i_paddr[15:SOC_SLOT_SHIFT]),
    .o_sel(wb_sel),
    .o_unmapped(w_unmapped)
);

apb_gpio gpio0 (
    .i_clk(i_clk),
    .i_reset(i_reset),
    .i_sel(wb_sel[SOC_SLOT_GPIO]),
    .i_penable(i_penable),
    .i_pwrite(i_pwrite),
    .i_paddr(i_paddr[4:0]),
    .i_pwdata(i_pwdata),
    .o_prdata(wb_prdata_gpio),
    .i_gpio(i_gpio),
    .o_gpio(o_gpio),
    .o_gpio_dir(o_gpio_dir),
    .o_irq_lines(wb_irq_gpio)
);

apb_irq_ctrl plic0 (
    .i_clk(i_clk),
    .i_reset(i_reset),
    .i_sel(wb_sel[SOC_SLOT_IRQ]),
    .i_penable(i_penable),
    .i_pwrite(i_pwrite),
    .i_paddr(i_paddr[3:0]),
    .i_pwdata(i_pwdata),
    .o_prdata(wb_prdata_irq),
    .i_gpio_irq(wb_irq_gpio),
    .o_irq(o_irq)
);

apb_pnp pnp0 (
    .i_clk(i_clk),
    .i_reset(i_reset),
    .i_sel(wb_sel[SOC_SLOT_PNP]),
    .i_penable(i_penable),
    .i_pwrite(i_pwrite),
    .i_paddr(i_paddr[5:0]),
    .i_pwdata(i_pwdata),
    .o_prdata(wb_prdata_pnp)
);

apb_resp_mux respmux0 (
    .i_sel(wb_sel),
    .i_unmapped(w_unmapped),
    .i_penable(i_penable),
    .i_prdata_gpio(wb_prdata_gpio),
    .i_prdata_irq(wb_prdata_irq),
    .i_prdata_pnp(wb_prdata_pnp),
    .o_prdata(o_prdata),
    .o_pready(o_pready),
    .o_pslverr(o_pslverr)
);

endmodule: periph_subsys

// ==== logic/soc_map_pkg.sv ====
package soc_map_pkg;

// Pin count of the GPIO block
localparam int SOC_GPIO_WIDTH = 12;

// APB slots, slot number is paddr[15:12]
localparam int SOC_SLOT_TOTAL = 3;
localparam int SOC_SLOT_GPIO  = 0;
localparam int SOC_SLOT_IRQ   = 1;
localparam int SOC_SLOT_PNP   = 2;
localparam int SOC_SLOT_SHIFT = 12;

// GPIO word offsets
localparam logic [4:0] GPIO_REG_INPUT  = 5'h00;             // Synchronized pin value
localparam logic [4:0] GPIO_REG_OUTPUT = 5'h04;
localparam logic [4:0] GPIO_REG_DIR    = 5'h08;             // 1 = output
localparam logic [4:0] GPIO_REG_IE     = 5'h0C;
localparam logic [4:0] GPIO_REG_PEND   = 5'h10;             // Write one to clear

// Interrupt controller offsets
localparam logic [3:0] IRQ_REG_PEND   = 4'h0;
localparam logic [3:0] IRQ_REG_ENABLE = 4'h4;
localparam logic [3:0] IRQ_REG_CLAIM  = 4'h8;

// Interrupt sources, id 0 means none
localparam int SOC_IRQ_TOTAL     = 16;
localparam int SOC_IRQ_GPIO_BASE = 1;                       // Pin n on source 1+n
localparam int SOC_IRQ_SOFT      = 15;                      // Set by software only

endpackage

// ==== logic/soc_pnp_pkg.sv ====
package soc_pnp_pkg;

// Board identification word at offset 0x00
localparam logic [31:0] SOC_HW_ID = 32'h5C0A_0103;

// Vendor code, upper half of each table entry
localparam logic [15:0] PNP_VENDOR_ID = 16'h00F1;

// Device codes, lower half of each table entry
localparam logic [15:0] PNP_DEV_GPIO = 16'h0060;
localparam logic [15:0] PNP_DEV_IRQ  = 16'h0061;
localparam logic [15:0] PNP_DEV_PNP  = 16'h0062;

// Register offsets
localparam logic [5:0] PNP_REG_SCRATCH = 6'h04;
localparam logic [5:0] PNP_REG_TABLE   = 6'h10;             // One word per slot from here

// One entry for every mapped slave
localparam int PNP_TABLE_SIZE = soc_map_pkg::SOC_SLOT_TOTAL;

endpackage

// ==== run.sh ====
#!/bin/sh
# Compile with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f tb.f --top-module periph_subsys_tb &&
./obj_dir/Vperiph_subsys_tb +verilator+error+limit+100 | tee /dev/stderr |
    grep -q "STATUS: PASS" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// ==== tb.f ====
logic/soc_map_pkg.sv
logic/soc_pnp_pkg.sv
logic/apb_slot_decoder.sv
logic/apb_gpio.sv
logic/apb_irq_ctrl.sv
logic/apb_pnp.sv
logic/apb_resp_mux.sv
logic/periph_subsys.sv
tb/periph_subsys_props.sv
tb/periph_subsys_tb.sv

// ==== tb/periph_subsys_props.sv ====
`timescale 1ns/1ps

module periph_subsys_props
(
    input logic i_clk,
    input logic i_reset,
    input logic i_psel,
    input logic i_penable,
    input logic i_pready,
    input logic i_pslverr,
    input logic i_irq
);

int fail_count = 0;                                         // Read by the testbench at the end

penable_needs_psel: assert property (@(posedge i_clk) disable iff (i_reset)
    i_penable |-> i_psel)
else
begin
    $error("penable high without psel");
    fail_count++;
end

// Zero wait states everywhere
ready_in_access: assert property (@(posedge i_clk) disable iff (i_reset)
    (i_psel && i_penable) |-> i_pready)
else
begin
    $error("pready low in an access cycle");
    fail_count++;
end

slverr_in_access: assert property (@(posedge i_clk) disable iff (i_reset)
    i_pslverr |-> (i_psel && i_penable))
else
begin
    $error("pslverr high outside an access cycle");
    fail_count++;
end

irq_low_after_reset: assert property (@(posedge i_clk) i_reset |=> !i_irq)
else
begin
    $error("o_irq high in the cycle after reset");
    fail_count++;
end

endmodule

bind periph_subsys periph_subsys_props props_inst (
    .i_clk(i_clk),
    .i_reset(i_reset),
    .i_psel(i_psel),
    .i_penable(i_penable),
    .i_pready(o_pready),
    .i_pslverr(o_pslverr),
    .i_irq(o_irq)
);

// ==== tb/periph_subsys_tb.sv ====
`timescale 1ns/1ps

module periph_subsys_tb;

localparam int CLK_HALF = 5;
localparam int READY_LIMIT = 8;                             // Access cycles before giving up

logic clk;
logic reset;
logic psel;
logic penable;
logic pwrite;
logic [15:0] paddr;
logic [31:0] pwdata;
logic pready;
logic [31:0] prdata;
logic pslverr;
logic [11:0] gpio_in;
logic [11:0] gpio_out;
logic [11:0] gpio_dir;
logic irq;

// One entry per trace line
string tr_op[$];
int tr_test[$];
logic [31:0] tr_arg[$];
logic [31:0] tr_wdata[$];
logic [31:0] tr_exp[$];

int check_errors = 0;
int err_base = 0;
int tests_passed = 0;
int tests_failed = 0;
bit load_failed = 0;
bit trace_loaded = 0;

periph_subsys periph_subsys_inst (
    .i_clk(clk),
    .i_reset(reset),
    .i_psel(psel),
    .i_penable(penable),
    .i_pwrite(pwrite),
    .i_paddr(paddr),
    .i_pwdata(pwdata),
    .o_pready(pready),
    .o_prdata(prdata),
    .o_pslverr(pslverr),
    .i_gpio(gpio_in),
    .o_gpio(gpio_out),
    .o_gpio_dir(gpio_dir),
    .o_irq(irq)
);

initial
begin
    clk = 1'b0;
    forever #CLK_HALF clk = ~clk;
end

// Slot numbers 3 to 15 have no slave
function automatic logic slot_unmapped(input logic [15:0] addr);
    return addr[15:12] > 4'd2;
endfunction

function automatic int total_errors();
    return check_errors + periph_subsys_inst.props_inst.fail_count;
endfunction

task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp)
    begin
        $display("CHECK FAILED at %0d ns: %s, got %h expected %h", $time, what, got, exp);
        check_errors++;
    end
endtask

task automatic load_trace();
    int fd;
    int cnt;
    string line;
    string op;
    int test;
    logic [31:0] arg;
    logic [31:0] wdata;
    logic [31:0] exp;
    fd = $fopen("tb/periph_trace.txt", "r");
    if (fd == 0)
    begin
        $display("ERROR: the trace file tb/periph_trace.txt could not be opened");
        load_failed = 1'b1;
    end
    else
    begin
        while ($fgets(line, fd) != 0)
        begin
            if (line.len() > 0 && line[0] != "#")                // Skip column notes
            begin
                cnt = $sscanf(line, "%s %d %h %h %h", op, test, arg, wdata, exp);
                if (cnt == 5)
                begin
                    tr_op.push_back(op);
                    tr_test.push_back(test);
                    tr_arg.push_back(arg);
                    tr_wdata.push_back(wdata);
                    tr_exp.push_back(exp);
                end
            end
        end
        $fclose(fd);
    end
    trace_loaded = 1'b1;
endtask

// Setup cycle then access cycle with sampling at its falling edge
task automatic apb_transfer(input logic wr, input logic [15:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
    int waited;
    @(posedge clk);
    #1;
    psel = 1'b1;
    penable = 1'b0;
    pwrite = wr;
    paddr = addr;
    pwdata = wdata;
    @(posedge clk);
    #1;
    penable = 1'b1;
    waited = 0;
    @(negedge clk);
    while (!pready && waited < READY_LIMIT)
    begin
        @(negedge clk);
        waited++;
    end
    if (!pready)
    begin
        $display("ERROR: no pready from the slave at address %h by %0d ns", addr, $time);
        check_errors++;
    end
    rdata = prdata;
    err = pslverr;
    @(posedge clk);
    #1;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
endtask

task automatic run_op(input int i);
    logic [31:0] rdata;
    logic err;
    case (tr_op[i])
        "wr":
        begin
            apb_transfer(1'b1, tr_arg[i][15:0], tr_wdata[i], rdata, err);
            check_value(32'(err), 32'(slot_unmapped(tr_arg[i][15:0])), "pslverr on write");
            @(negedge clk);
            if (tr_arg[i][15:0] == 16'h0004)                     // Output register drives pins
            begin
                check_value(32'(gpio_out), 32'(tr_wdata[i][11:0]), "o_gpio after write");
            end
            if (tr_arg[i][15:0] == 16'h0008)
            begin
                check_value(32'(gpio_dir), 32'(tr_wdata[i][11:0]), "o_gpio_dir after write");
            end
        end
        "rd":
        begin
            apb_transfer(1'b0, tr_arg[i][15:0], 32'h0, rdata, err);
            check_value(32'(err), 32'(slot_unmapped(tr_arg[i][15:0])), "pslverr on read");
            check_value(rdata, tr_exp[i], $sformatf("read data at %h", tr_arg[i][15:0]));
        end
        "gpio":
        begin
            @(posedge clk);
            #1;
            gpio_in = tr_arg[i][11:0];
        end
        "wait": repeat (tr_arg[i]) @(posedge clk);
        "irq":
        begin
            @(negedge clk);
            check_value(32'(irq), tr_exp[i], "o_irq level");
        end
        "end":
        begin
            if (total_errors() == err_base)
            begin
                $display("test %0d passed", tr_test[i]);
                tests_passed++;
            end
            else
            begin
                $display("test %0d failed with %0d errors", tr_test[i], total_errors() - err_base);
                tests_failed++;
            end
            err_base = total_errors();
        end
        default:
        begin
            $display("ERROR: unknown trace operation %s at trace entry %0d", tr_op[i], i);
            check_errors++;
        end
    endcase
endtask

task automatic finish_run();
    $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
    if (!load_failed && total_errors() == 0 && tests_failed == 0)
    begin
        $display("STATUS: PASS");
    end
    else
    begin
        $display("STATUS: FAIL");
    end
    $finish;
endtask

initial
begin
    reset = 1'b1;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    gpio_in = '0;
    load_trace();
    repeat (4) @(posedge clk);
    #1;
    reset = 1'b0;
    @(negedge clk);
    check_value(32'(gpio_out), 32'h0, "o_gpio after reset");
    check_value(32'(gpio_dir), 32'h0, "o_gpio_dir after reset");
    check_value(32'(irq), 32'h0, "o_irq after reset");
    for (int i = 0; i < tr_op.size(); i++)
    begin
        run_op(i);
    end
    finish_run();
end

// Watchdog sized from the trace length
initial
begin
    int limit;
    wait (trace_loaded);
    limit = 20 * tr_op.size() + 200;
    repeat (limit) @(posedge clk);
    $display("ERROR: timeout, the run did not finish within %0d cycles", limit);
    $display("STATUS: FAIL");
    $finish;
end

endmodule

// ==== tb/periph_trace.txt ====
# op test arg wdata expected, all columns after the test number in hex
# arg is the APB address, the pin pattern for gpio or the cycle count for wait
rd   1 0004 00000000 00000000
rd   1 0008 00000000 00000000
wr   1 0004 00000a5c 00000000
wr   1 0008 000000f0 00000000
rd   1 0004 00000000 00000a5c
rd   1 0008 00000000 000000f0
wr   1 0008 00000000 00000000
end  1 0000 00000000 00000000
gpio 2 036c 00000000 00000000
wait 2 0002 00000000 00000000
rd   2 0000 00000000 0000036c
gpio 2 0000 00000000 00000000
wait 2 0002 00000000 00000000
wr   2 0010 00000fff 00000000
rd   2 0010 00000000 00000000
end  2 0000 00000000 00000000
wr   3 000c 00000fff 00000000
wr   3 1004 0000fffe 00000000
gpio 3 0008 00000000 00000000
wait 3 0005 00000000 00000000
irq  3 0000 00000000 00000001
wr   3 0010 00000008 00000000
rd   3 1008 00000000 00000004
irq  3 0000 00000000 00000000
gpio 3 00a8 00000000 00000000
wait 3 0005 00000000 00000000
irq  3 0000 00000000 00000001
wr   3 0010 000000a0 00000000
rd   3 1008 00000000 00000006
rd   3 1008 00000000 00000008
irq  3 0000 00000000 00000000
wr   3 0008 00000800 00000000
gpio 3 08a8 00000000 00000000
wait 3 0005 00000000 00000000
rd   3 0010 00000000 00000000
rd   3 1000 00000000 00000000
irq  3 0000 00000000 00000000
end  3 0000 00000000 00000000
rd   4 1008 00000000 00000000
wr   4 1000 00008000 00000000
irq  4 0000 00000000 00000001
rd   4 1000 00000000 00008000
rd   4 1008 00000000 0000000f
irq  4 0000 00000000 00000000
end  4 0000 00000000 00000000
rd   5 2000 00000000 5c0a0103
rd   5 2010 00000000 00f10060
rd   5 2014 00000000 00f10061
rd   5 2018 00000000 00f10062
rd   5 2004 00000000 00000000
wr   5 2004 13579bdf 00000000
rd   5 2004 00000000 13579bdf
rd   5 2008 00000000 00000000
rd   5 201c 00000000 00000000
end  5 0000 00000000 00000000
wr   6 0004 00000123 00000000
wr   6 3004 00000fff 00000000
rd   6 3004 00000000 00000000
rd   6 f004 00000000 00000000
rd   6 0004 00000000 00000123
end  6 0000 00000000 00000000
